// ==== p2p_stream_pkg.sv ====
/*
 * Stream definitions for the point-to-point bypass.
 * Describes one beat of a switch stream lane: payload, byte enables,
 * end of packet and the sideband fields that ride along with the data.
 * The valid/ready handshake is kept outside the beat struct.
 */

package p2p_stream_pkg;

   // --------------------
   // Field widths
   // --------------------

   // Payload is eight bytes wide, with one keep bit per byte
   localparam int STREAM_DATA_WIDTH = 64;
   localparam int STREAM_KEEP_WIDTH = STREAM_DATA_WIDTH / 8;

   // Sideband widths as the switch shell presents them
   localparam int STREAM_ID_WIDTH   = 8;
   localparam int STREAM_DEST_WIDTH = 8;
   localparam int STREAM_USER_WIDTH = 16;

   // --------------------
   // Beat types
   // --------------------

   typedef logic [STREAM_DATA_WIDTH-1:0] stream_data_t;
   typedef logic [STREAM_KEEP_WIDTH-1:0] stream_keep_t;
   typedef logic [STREAM_ID_WIDTH-1:0]   stream_id_t;
   typedef logic [STREAM_DEST_WIDTH-1:0] stream_dest_t;
   typedef logic [STREAM_USER_WIDTH-1:0] stream_user_t;

   // One beat as it crosses a lane; tid and tdest are carried, never routed on
   typedef struct packed {
      stream_data_t tdata;
      stream_keep_t tkeep;
      logic         tlast;
      stream_id_t   tid;
      stream_dest_t tdest;
      stream_user_t tuser;
   } stream_beat_t;

endpackage

// ==== p2p_reg_pkg.sv ====
/*
 * Register bus definitions for the point-to-point bypass.
 * Holds the strobe-based request and response structs, the register
 * offsets of the control and status blocks, and the rule that picks
 * the block from the address.
 */

package p2p_reg_pkg;

   // --------------------
   // Bus widths and types
   // --------------------

   localparam int REG_ADDR_WIDTH  = 8;
   localparam int REG_DATA_WIDTH  = 32;
   localparam int TIMESTAMP_WIDTH = 64;

   typedef logic [REG_ADDR_WIDTH-1:0]  reg_addr_t;
   typedef logic [REG_DATA_WIDTH-1:0]  reg_data_t;
   typedef logic [TIMESTAMP_WIDTH-1:0] timestamp_t;

   // Wr and rd are single-cycle strobes and never high together
   typedef struct packed {
      logic      wr;
      logic      rd;
      reg_addr_t addr;
      reg_data_t wdata;
   } reg_req_t;

   // Rvalid marks the cycle after a read strobe
   typedef struct packed {
      logic      rvalid;
      reg_data_t rdata;
   } reg_rsp_t;

   // --------------------
   // Register offsets
   // --------------------

   // Control block
   localparam reg_addr_t REG_ID       = 8'h00;
   localparam reg_addr_t REG_CONTROL  = 8'h04;
   localparam reg_addr_t REG_SCRATCH  = 8'h08;
   localparam reg_addr_t REG_BEATS_0  = 8'h0C;
   localparam reg_addr_t REG_BEATS_1  = 8'h10;

   // Status block
   localparam reg_addr_t REG_TS_LATCH = 8'h80;
   localparam reg_addr_t REG_TS_UPPER = 8'h84;
   localparam reg_addr_t REG_TS_LOWER = 8'h88;

   // Bit positions inside REG_CONTROL
   localparam int TPAUSE_BIT = 0;

   // --------------------
   // Block select
   // --------------------

   // Address bit 7 set means the status block owns the offset
   localparam int STATUS_SEL_BIT = 7;

   function automatic logic is_status_addr(input reg_addr_t addr);
      return addr[STATUS_SEL_BIT];
   endfunction

endpackage

// ==== p2p_reg_decoder.sv ====
/*
 * Register decoder.
 * Steers the read and write strobes of the register bus to either the
 * control block or the status block, and folds the two registered read
 * responses back into one response for the bus.
 */

module p2p_reg_decoder
   import p2p_reg_pkg::*;
(
   input  logic     core_clk,
   input  logic     reset,

   // Register bus from outside
   input  reg_req_t reg_req,
   output reg_rsp_t reg_rsp,

   // Control block side
   output reg_req_t ctrl_req,
   input  reg_rsp_t ctrl_rsp,

   // Status block side
   output reg_req_t status_req,
   input  reg_rsp_t status_rsp
);

   // Steering and merge are purely combinational
   // Both blocks register their own responses

   logic      sel_status;
   reg_data_t ctrl_rdata_masked;
   reg_data_t status_rdata_masked;

   // --------------------
   // Request steering
   // --------------------

   assign sel_status = is_status_addr(reg_req.addr);

   // Address and write data go to both blocks unchanged
   // Only the strobes are gated, so a block never acts on the other's offsets
   always_comb begin
      ctrl_req    = reg_req;
      ctrl_req.wr = reg_req.wr && !sel_status;
      ctrl_req.rd = reg_req.rd && !sel_status;
   end

   always_comb begin
      status_req    = reg_req;
      status_req.wr = reg_req.wr && sel_status;
      status_req.rd = reg_req.rd && sel_status;
   end

   // --------------------
   // Response merge
   // --------------------

   // At most one block answers in a cycle, since a read goes to only one of them
   assign ctrl_rdata_masked   = {REG_DATA_WIDTH{ctrl_rsp.rvalid}} & ctrl_rsp.rdata;
   assign status_rdata_masked = {REG_DATA_WIDTH{status_rsp.rvalid}} & status_rsp.rdata;

   // Idle cycles return zero data so the bus never shows stale words
   always_comb begin
      reg_rsp.rvalid = ctrl_rsp.rvalid || status_rsp.rvalid;
      reg_rsp.rdata  = ctrl_rdata_masked | status_rdata_masked;
   end

endmodule

// ==== p2p_ctrl_regs.sv ====
/*
 * Control register block.
 * Holds the identity word, the pause control and a scratch register,
 * reads back the two lane beat counters zero-extended to the bus width,
 * and issues the clear pulses for those counters.
 */

module p2p_ctrl_regs
   import p2p_reg_pkg::*;
#(
   parameter reg_data_t P2P_ID           = 32'h5032_5030,
   parameter int        BEAT_COUNT_WIDTH = 32
) (
   input  logic                        core_clk,
   input  logic                        reset,

   input  reg_req_t                    reg_req,
   output reg_rsp_t                    reg_rsp,

   // Counter values from the bypass lanes
   input  logic [BEAT_COUNT_WIDTH-1:0] beats_0,
   input  logic [BEAT_COUNT_WIDTH-1:0] beats_1,

   output logic                        tpause,
   output logic                        clear_beats_0,
   output logic                        clear_beats_1
);

   reg_data_t scratch;
   reg_data_t control_word;
   reg_data_t rdata_nxt;
   reg_data_t rsp_data;
   logic      rsp_valid;

   // --------------------
   // Write side
   // --------------------

   // Control and scratch take the write on the edge of the strobe
   always_ff @(posedge core_clk) begin
      if (reset) begin
         tpause  <= 1'b0;
         scratch <= '0;
      end else if (reg_req.wr) begin
         if (reg_req.addr == REG_CONTROL) begin
            tpause <= reg_req.wdata[TPAUSE_BIT];
         end
         if (reg_req.addr == REG_SCRATCH) begin
            scratch <= reg_req.wdata;
         end
      end
   end

   // A write of any value to a counter offset clears that counter
   // The pulse is combinational so the counter clears on the same edge
   assign clear_beats_0 = reg_req.wr && (reg_req.addr == REG_BEATS_0);
   assign clear_beats_1 = reg_req.wr && (reg_req.addr == REG_BEATS_1);

   // --------------------
   // Read side
   // --------------------

   always_comb begin
      control_word             = '0;
      control_word[TPAUSE_BIT] = tpause;
   end

   // Unmapped offsets fall through to zero
   always_comb begin
      case (reg_req.addr)
         REG_ID:      rdata_nxt = P2P_ID;
         REG_CONTROL: rdata_nxt = control_word;
         REG_SCRATCH: rdata_nxt = scratch;
         REG_BEATS_0: rdata_nxt = reg_data_t'(beats_0);
         REG_BEATS_1: rdata_nxt = reg_data_t'(beats_1);
         default:     rdata_nxt = '0;
      endcase
   end

   // Response comes one cycle after the read strobe
   always_ff @(posedge core_clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= reg_req.rd;
      end
   end

   always_ff @(posedge core_clk) begin
      if (reg_req.rd) begin
         rsp_data <= rdata_nxt;
      end
   end

   assign reg_rsp = '{rvalid: rsp_valid, rdata: rsp_data};

endmodule

// ==== sdnet_status_regs.sv ====
/*
 * Timestamp status register block.
 * A write to the latch command offset captures the free-running
 * timestamp, and the two status offsets return the upper and lower
 * words of the captured value until the next latch command.
 */

module sdnet_status_regs
   import p2p_reg_pkg::*;
(
   input  logic       core_clk,
   input  logic       reset,

   input  reg_req_t   reg_req,
   output reg_rsp_t   reg_rsp,

   // Free-running time from the shell
   input  timestamp_t timestamp
);

   timestamp_t ts_latch;
   logic       latch_cmd;
   reg_data_t  rdata_nxt;
   reg_data_t  rsp_data;
   logic       rsp_valid;

   // --------------------
   // Timestamp capture
   // --------------------

   // The write data is ignored; only the offset carries the command
   assign latch_cmd = reg_req.wr && (reg_req.addr == REG_TS_LATCH);

   // The captured value is the one present on the edge of the command
   always_ff @(posedge core_clk) begin
      if (reset) begin
         ts_latch <= '0;
      end else if (latch_cmd) begin
         ts_latch <= timestamp;
      end
   end

   // --------------------
   // Readback
   // --------------------

   // REG_TS_LATCH itself is a command offset and reads as zero
   always_comb begin
      case (reg_req.addr)
         REG_TS_UPPER: rdata_nxt = ts_latch[TIMESTAMP_WIDTH-1 -: REG_DATA_WIDTH];
         REG_TS_LOWER: rdata_nxt = ts_latch[REG_DATA_WIDTH-1:0];
         default:      rdata_nxt = '0;
      endcase
   end

   always_ff @(posedge core_clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= reg_req.rd;
      end
   end

   // Read data is held between reads
   always_ff @(posedge core_clk) begin
      if (reg_req.rd) begin
         rsp_data <= rdata_nxt;
      end
   end

   assign reg_rsp = '{rvalid: rsp_valid, rdata: rsp_data};

endmodule

// ==== p2p_bypass.sv ====
/*
 * Two-lane stream bypass.
 * Each lane hands beats from the switch straight back to the switch with
 * no register stage. Lane 0 can be paused, which blocks both its valid
 * and its ready. Every accepted beat bumps a wrapping per-lane counter.
 */

module p2p_bypass
   import p2p_stream_pkg::*;
#(
   parameter int BEAT_COUNT_WIDTH = 32
) (
   input  logic                        core_clk,
   input  logic                        reset,

   input  logic                        tpause,

   // Lane inputs from the switch
   input  stream_beat_t                from_switch_0,
   input  logic                        from_valid_0,
   output logic                        from_ready_0,
   input  stream_beat_t                from_switch_1,
   input  logic                        from_valid_1,
   output logic                        from_ready_1,

   // Lane outputs back to the switch
   output stream_beat_t                to_switch_0,
   output logic                        to_valid_0,
   input  logic                        to_ready_0,
   output stream_beat_t                to_switch_1,
   output logic                        to_valid_1,
   input  logic                        to_ready_1,

   // Counter control and readback
   input  logic                        clear_beats_0,
   input  logic                        clear_beats_1,
   output logic [BEAT_COUNT_WIDTH-1:0] beats_0,
   output logic [BEAT_COUNT_WIDTH-1:0] beats_1
);

   typedef logic [BEAT_COUNT_WIDTH-1:0] beat_count_t;

   logic [1:0]  accept;
   logic [1:0]  clear;
   beat_count_t count [2];

   // --------------------
   // Lane 0, pausable
   // --------------------

   // The payload always follows; only the handshake is blocked by pause
   assign to_switch_0  = from_switch_0;
   assign to_valid_0   = from_valid_0 && !tpause;
   assign from_ready_0 = to_ready_0 && !tpause;

   // --------------------
   // Lane 1, plain wire
   // --------------------

   assign to_switch_1  = from_switch_1;
   assign to_valid_1   = from_valid_1;
   assign from_ready_1 = to_ready_1;

   // --------------------
   // Beat counters
   // --------------------

   // A beat counts when it leaves the lane, so paused beats never count
   assign accept = {to_valid_1 && to_ready_1, to_valid_0 && to_ready_0};
   assign clear  = {clear_beats_1, clear_beats_0};

   // Clear wins over a beat in the same cycle; counts wrap at full scale
   always_ff @(posedge core_clk) begin
      for (int lane = 0; lane < 2; lane++) begin
         if (reset || clear[lane]) begin
            count[lane] <= '0;
         end else if (accept[lane]) begin
            count[lane] <= count[lane] + 1'b1;
         end
      end
   end

   assign beats_0 = count[0];
   assign beats_1 = count[1];

endmodule

// ==== p2p.sv ====
/*
 * Point-to-point bypass top level.
 * Ties the register decoder, the control and timestamp status register
 * blocks and the two-lane stream bypass together on core_clk.
 */

module p2p
   import p2p_reg_pkg::*;
   import p2p_stream_pkg::*;
#(
   parameter reg_data_t P2P_ID           = 32'h5032_5030,
   parameter int        BEAT_COUNT_WIDTH = 32
) (
   input  logic         core_clk,
   input  logic         reset,
   input  timestamp_t   timestamp,

   // Register bus
   input  reg_req_t     reg_req,
   output reg_rsp_t     reg_rsp,

   // Stream lanes from the switch
   input  stream_beat_t from_switch_0,
   input  logic         from_valid_0,
   output logic         from_ready_0,
   input  stream_beat_t from_switch_1,
   input  logic         from_valid_1,
   output logic         from_ready_1,

   // Stream lanes back to the switch
   output stream_beat_t to_switch_0,
   output logic         to_valid_0,
   input  logic         to_ready_0,
   output stream_beat_t to_switch_1,
   output logic         to_valid_1,
   input  logic         to_ready_1
);

   // --------------------
   // Register path
   // --------------------

   reg_req_t ctrl_req;
   reg_rsp_t ctrl_rsp;
   reg_req_t status_req;
   reg_rsp_t status_rsp;

   // Controls between the control block and the lanes
   logic                        tpause;
   logic                        clear_beats_0;
   logic                        clear_beats_1;
   logic [BEAT_COUNT_WIDTH-1:0] beats_0;
   logic [BEAT_COUNT_WIDTH-1:0] beats_1;

   p2p_reg_decoder u_reg_decoder (
      .core_clk   (core_clk),
      .reset      (reset),
      .reg_req    (reg_req),
      .reg_rsp    (reg_rsp),
      .ctrl_req   (ctrl_req),
      .ctrl_rsp   (ctrl_rsp),
      .status_req (status_req),
      .status_rsp (status_rsp)
   );

   p2p_ctrl_regs #(
      .P2P_ID           (P2P_ID),
      .BEAT_COUNT_WIDTH (BEAT_COUNT_WIDTH)
   ) u_ctrl_regs (
      .core_clk      (core_clk),
      .reset         (reset),
      .reg_req       (ctrl_req),
      .reg_rsp       (ctrl_rsp),
      .beats_0       (beats_0),
      .beats_1       (beats_1),
      .tpause        (tpause),
      .clear_beats_0 (clear_beats_0),
      .clear_beats_1 (clear_beats_1)
   );

   // Timestamp capture runs beside the control block
   sdnet_status_regs u_status_regs (
      .core_clk  (core_clk),
      .reset     (reset),
      .reg_req   (status_req),
      .reg_rsp   (status_rsp),
      .timestamp (timestamp)
   );

   // --------------------
   // Stream path
   // --------------------

   p2p_bypass #(
      .BEAT_COUNT_WIDTH (BEAT_COUNT_WIDTH)
   ) u_bypass (
      .core_clk      (core_clk),
      .reset         (reset),
      .tpause        (tpause),
      .from_switch_0 (from_switch_0),
      .from_valid_0  (from_valid_0),
      .from_ready_0  (from_ready_0),
      .from_switch_1 (from_switch_1),
      .from_valid_1  (from_valid_1),
      .from_ready_1  (from_ready_1),
      .to_switch_0   (to_switch_0),
      .to_valid_0    (to_valid_0),
      .to_ready_0    (to_ready_0),
      .to_switch_1   (to_switch_1),
      .to_valid_1    (to_valid_1),
      .to_ready_1    (to_ready_1),
      .clear_beats_0 (clear_beats_0),
      .clear_beats_1 (clear_beats_1),
      .beats_0       (beats_0),
      .beats_1       (beats_1)
   );

endmodule

// ==== p2p_chk.sv ====
/*
 * Assertion checker for the p2p top level.
 * Watches the lane 0 pause gating, the lane 1 pass-through handshake
 * and the one-cycle timing of the register read response.
 */

module p2p_chk
   import p2p_reg_pkg::*;
(
   input logic     core_clk,
   input logic     reset,
   input logic     tpause,
   input reg_req_t reg_req,
   input reg_rsp_t reg_rsp,
   input logic     to_valid_0,
   input logic     from_ready_0,
   input logic     from_valid_1,
   input logic     to_valid_1,
   input logic     from_ready_1,
   input logic     to_ready_1
);

   timeunit 1ns;
   timeprecision 1ps;

   // --------------------
   // Stream lanes
   // --------------------

   // Pause blocks both directions of the lane 0 handshake
   pause_blocks_lane_0: assert property (@(posedge core_clk) disable iff (reset)
      tpause |-> (!to_valid_0 && !from_ready_0))
      else $error("Lane 0 handshake active while tpause is set");

   // Lane 1 is a plain wire for valid and ready
   lane_1_passes: assert property (@(posedge core_clk) disable iff (reset)
      (to_valid_1 == from_valid_1) && (from_ready_1 == to_ready_1))
      else $error("Lane 1 valid or ready differs from its source");

   // --------------------
   // Register reads
   // --------------------

   // Every read strobe is answered on the next cycle
   read_gets_rvalid: assert property (@(posedge core_clk) disable iff (reset)
      reg_req.rd |=> reg_rsp.rvalid)
      else $error("No rvalid one cycle after a read strobe");

   // And rvalid never shows up without a strobe before it
   rvalid_needs_read: assert property (@(posedge core_clk) disable iff (reset)
      reg_rsp.rvalid |-> $past(reg_req.rd))
      else $error("Rvalid without a read strobe in the previous cycle");

endmodule

bind p2p p2p_chk u_chk (
   .core_clk     (core_clk),
   .reset        (reset),
   .tpause       (tpause),
   .reg_req      (reg_req),
   .reg_rsp      (reg_rsp),
   .to_valid_0   (to_valid_0),
   .from_ready_0 (from_ready_0),
   .from_valid_1 (from_valid_1),
   .to_valid_1   (to_valid_1),
   .from_ready_1 (from_ready_1),
   .to_ready_1   (to_ready_1)
);

// ==== p2p_tb.sv ====
/*
 * Directed testbench for the point-to-point bypass.
 * Drives the register bus, both stream lanes and a running timestamp,
 * and checks readback, pass-through, pause, beat counts and the latch.
 */

module p2p_tb
   import p2p_reg_pkg::*;
   import p2p_stream_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam reg_data_t  TB_P2P_ID = 32'h5032_5030;
   localparam int         NUM_TESTS = 5;
   // Step touches both words so the upper half moves too
   localparam timestamp_t TS_STEP   = 64'h0000_0001_0000_0003;

   logic         core_clk = 1'b0;
   logic         reset;
   timestamp_t   timestamp;
   reg_req_t     reg_req;
   reg_rsp_t     reg_rsp;
   stream_beat_t from_switch_0;
   stream_beat_t from_switch_1;
   stream_beat_t to_switch_0;
   stream_beat_t to_switch_1;
   logic         from_valid_0;
   logic         from_valid_1;
   logic         from_ready_0;
   logic         from_ready_1;
   logic         to_valid_0;
   logic         to_valid_1;
   logic         to_ready_0;
   logic         to_ready_1;

   integer       seed;
   int           errors;
   int           checks;
   int           exp_beats_0;
   int           exp_beats_1;

   always #4 core_clk = ~core_clk;

   // Free-running time, moved on the falling edge like every other input
   always @(negedge core_clk) timestamp <= timestamp + TS_STEP;

   p2p #(
      .P2P_ID           (TB_P2P_ID),
      .BEAT_COUNT_WIDTH (32)
   ) dut (
      .core_clk      (core_clk),
      .reset         (reset),
      .timestamp     (timestamp),
      .reg_req       (reg_req),
      .reg_rsp       (reg_rsp),
      .from_switch_0 (from_switch_0),
      .from_valid_0  (from_valid_0),
      .from_ready_0  (from_ready_0),
      .from_switch_1 (from_switch_1),
      .from_valid_1  (from_valid_1),
      .from_ready_1  (from_ready_1),
      .to_switch_0   (to_switch_0),
      .to_valid_0    (to_valid_0),
      .to_ready_0    (to_ready_0),
      .to_switch_1   (to_switch_1),
      .to_valid_1    (to_valid_1),
      .to_ready_1    (to_ready_1)
   );

   // --------------------
   // Helpers
   // --------------------

   task automatic check(input string name, input logic [127:0] actual,
                        input logic [127:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      end
   endtask

   task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
      @(negedge core_clk);
      reg_req.wr    = 1'b1;
      reg_req.addr  = addr;
      reg_req.wdata = data;
      @(negedge core_clk);
      reg_req.wr = 1'b0;
   endtask

   // The response is registered, so it is stable at the next falling edge
   task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
      @(negedge core_clk);
      reg_req.rd   = 1'b1;
      reg_req.addr = addr;
      @(negedge core_clk);
      reg_req.rd = 1'b0;
      data       = reg_rsp.rdata;
      if (!reg_rsp.rvalid) begin
         errors++;
         $display("Read of offset 0x%02h got no rvalid one cycle after the strobe", addr);
      end
   endtask

   task automatic read_expect(input reg_addr_t addr, input string name,
                              input reg_data_t expected);
      reg_data_t data;
      reg_read(addr, data);
      check(name, data, expected);
   endtask

   function automatic stream_beat_t random_beat();
      stream_beat_t beat;
      logic [31:0]  side;
      logic [31:0]  user;
      beat.tdata = {$random(seed), $random(seed)};
      side       = $random(seed);
      user       = $random(seed);
      beat.tkeep = side[7:0];
      beat.tid   = side[15:8];
      beat.tdest = side[23:16];
      beat.tlast = side[24];
      beat.tuser = user[15:0];
      return beat;
   endfunction

   // One cycle of random beats and handshakes, with the expected acceptances
   task automatic drive_cycle(input logic paused);
      logic [31:0] hs;
      @(negedge core_clk);
      hs            = $random(seed);
      from_switch_0 = random_beat();
      from_switch_1 = random_beat();
      from_valid_0  = hs[0];
      to_ready_0    = hs[1];
      from_valid_1  = hs[2];
      to_ready_1    = hs[3];
      if (hs[0] && hs[1] && !paused) exp_beats_0++;
      if (hs[2] && hs[3]) exp_beats_1++;
   endtask

   task automatic idle_streams();
      @(negedge core_clk);
      from_valid_0 = 1'b0;
      from_valid_1 = 1'b0;
   endtask

   // Both lanes offered a fresh beat with the far side ready
   task automatic offer_beats(output stream_beat_t beat_0, output stream_beat_t beat_1);
      @(negedge core_clk);
      beat_0        = random_beat();
      beat_1        = random_beat();
      from_switch_0 = beat_0;
      from_switch_1 = beat_1;
      from_valid_0  = 1'b1;
      from_valid_1  = 1'b1;
      to_ready_0    = 1'b1;
      to_ready_1    = 1'b1;
      @(posedge core_clk);
   endtask

   // --------------------
   // Tests
   // --------------------

   task automatic test_reset_values();
      read_expect(REG_ID, "REG_ID", TB_P2P_ID);
      read_expect(REG_CONTROL, "REG_CONTROL", '0);
      read_expect(REG_BEATS_0, "REG_BEATS_0", '0);
      read_expect(REG_BEATS_1, "REG_BEATS_1", '0);
      read_expect(REG_SCRATCH, "REG_SCRATCH", '0);
      reg_write(REG_SCRATCH, 32'hA5C3_0F96);
      read_expect(REG_SCRATCH, "REG_SCRATCH", 32'hA5C3_0F96);
      // Unmapped offsets in each block
      read_expect(8'h40, "rdata at 0x40", '0);
      read_expect(8'h8C, "rdata at 0x8C", '0);
   endtask

   task automatic test_pass_through();
      stream_beat_t beat_0;
      stream_beat_t beat_1;
      for (int i = 0; i < 8; i++) begin
         offer_beats(beat_0, beat_1);
         check("to_switch_0", to_switch_0, beat_0);
         check("to_switch_1", to_switch_1, beat_1);
         check("to_valid_0", to_valid_0, 1'b1);
         check("to_valid_1", to_valid_1, 1'b1);
         check("from_ready_0", from_ready_0, 1'b1);
         check("from_ready_1", from_ready_1, 1'b1);
      end
      @(negedge core_clk);
      to_ready_0 = 1'b0;
      @(posedge core_clk);
      check("from_ready_0", from_ready_0, 1'b0);
      check("from_ready_1", from_ready_1, 1'b1);
      @(negedge core_clk);
      to_ready_1 = 1'b0;
      @(posedge core_clk);
      check("from_ready_1", from_ready_1, 1'b0);
      idle_streams();
   endtask

   task automatic test_pause();
      stream_beat_t beat_0;
      stream_beat_t beat_1;
      reg_write(REG_CONTROL, 32'h1);
      read_expect(REG_CONTROL, "REG_CONTROL", 32'h1);
      for (int i = 0; i < 4; i++) begin
         offer_beats(beat_0, beat_1);
         check("to_valid_0", to_valid_0, 1'b0);
         check("from_ready_0", from_ready_0, 1'b0);
         check("to_valid_1", to_valid_1, 1'b1);
         check("from_ready_1", from_ready_1, 1'b1);
         check("to_switch_1", to_switch_1, beat_1);
      end
      reg_write(REG_CONTROL, 32'h0);
      offer_beats(beat_0, beat_1);
      check("to_valid_0", to_valid_0, 1'b1);
      check("from_ready_0", from_ready_0, 1'b1);
      check("to_switch_0", to_switch_0, beat_0);
      idle_streams();
   endtask

   task automatic test_beat_counters();
      reg_write(REG_BEATS_0, 32'h0);
      reg_write(REG_BEATS_1, 32'h0);
      exp_beats_0 = 0;
      exp_beats_1 = 0;
      repeat (30) drive_cycle(1'b0);
      idle_streams();
      // Lane 0 beats offered while paused must not count
      reg_write(REG_CONTROL, 32'h1);
      repeat (20) drive_cycle(1'b1);
      idle_streams();
      reg_write(REG_CONTROL, 32'h0);
      read_expect(REG_BEATS_0, "REG_BEATS_0", exp_beats_0);
      read_expect(REG_BEATS_1, "REG_BEATS_1", exp_beats_1);
      // Any written value clears, and only the addressed counter
      reg_write(REG_BEATS_0, 32'hFFFF_FFFF);
      read_expect(REG_BEATS_0, "REG_BEATS_0", '0);
      read_expect(REG_BEATS_1, "REG_BEATS_1", exp_beats_1);
      reg_write(REG_BEATS_1, 32'h0);
      read_expect(REG_BEATS_1, "REG_BEATS_1", '0);
   endtask

   task automatic test_timestamp();
      timestamp_t latched;
      @(negedge core_clk);
      reg_req.wr    = 1'b1;
      reg_req.addr  = REG_TS_LATCH;
      reg_req.wdata = '0;
      // Timestamp only changes on falling edges, so this is the latched value
      @(posedge core_clk);
      latched = timestamp;
      @(negedge core_clk);
      reg_req.wr = 1'b0;
      repeat (5) @(negedge core_clk);
      // The control block keeps a nonzero word from this read while idle
      read_expect(REG_SCRATCH, "REG_SCRATCH", 32'hA5C3_0F96);
      read_expect(REG_TS_UPPER, "REG_TS_UPPER", latched[63:32]);
      read_expect(REG_TS_LOWER, "REG_TS_LOWER", latched[31:0])
      ;
      // Now the status block holds a stale word beside the control response
      read_expect(REG_SCRATCH, "REG_SCRATCH", 32'hA5C3_0F96);
   endtask

   // --------------------
   // Sequence and watchdog
   // --------------------

   initial begin
      seed          = 32'h3526;
      errors        = 0;
      checks        = 0;
      exp_beats_0   = 0;
      exp_beats_1   = 0;
      reset         = 1'b1;
      reg_req       = '0;
      timestamp     = 64'h0000_00A5_FFFF_FFF0;
      from_switch_0 = '0;
      from_switch_1 = '0;
      from_valid_0  = 1'b0;
      from_valid_1  = 1'b0;
      to_ready_0    = 1'b0;
      to_ready_1    = 1'b0;
      repeat (2) @(posedge core_clk);
      @(negedge core_clk);
      reset = 1'b0;

      test_reset_values();
      test_pass_through();
      test_pause();
      test_beat_counters();
      test_timestamp();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

   initial begin
      #(NUM_TESTS * 2000);
      $display("Watchdog expired before the tests finished, errors so far: %0d", errors);
      $display("Test FAILED");
      $finish;
   end

endmodule

// ==== p2p.f ====
p2p_stream_pkg.sv
p2p_reg_pkg.sv
p2p_reg_decoder.sv
p2p_ctrl_regs.sv
sdnet_status_regs.sv
p2p_bypass.sv
p2p.sv
p2p_chk.sv
p2p_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the p2p testbench with Verilator, runs it and looks for the pass line.
# The exit status is nonzero when the build fails or the pass line is missing.
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module p2p_tb -f p2p.f \
   && ./obj_dir/Vp2p_tb | tee /dev/stderr | grep -x "Test OK" > /dev/null \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }
